//--- fxp_format_pkg.sv
package fxp_format_pkg;

    // ------------------------------------------------------------------------
    // input format, signed Q8.8
    // ------------------------------------------------------------------------
    localparam int din_i  = 8;                  // integer bits, sign included
    localparam int din_f  = 8;                  // fractional bits
    localparam int din_w  = din_i + din_f;      // 16
    localparam int mag_w  = din_w - 1;          // magnitude of an operand, 15

    // ------------------------------------------------------------------------
    // intermediate quotient magnitude, unsigned Q15.8
    // ------------------------------------------------------------------------
    localparam int qmag_w = mag_w + din_f;      // 23, one bit per divider step

    // ------------------------------------------------------------------------
    // output format, signed Q12.12
    // ------------------------------------------------------------------------
    localparam int dout_i = 12;                 // integer bits, sign included
    localparam int dout_f = 12;                 // fractional bits
    localparam int dout_w = dout_i + dout_f;    // 24

    // alignment from Q15.8 up to 12 fraction bits
    localparam int align_sh = dout_f - din_f;   // left shift, 4
    localparam int align_w  = qmag_w + align_sh; // aligned magnitude, 27

    // ------------------------------------------------------------------------
    // word types
    // ------------------------------------------------------------------------
    typedef logic signed [din_w-1:0]  din_t;    // operand word
    typedef logic signed [dout_w-1:0] dout_t;   // result word
    typedef logic        [qmag_w-1:0] qmag_t;   // unsigned divider quotient

    // clamp limits of the output word
    localparam dout_t dout_max = dout_t'((1 << (dout_w - 1)) - 1);   // +2047.999
    localparam dout_t dout_min = dout_t'(-(1 << (dout_w - 1)));      // -2048.0

endpackage

//--- div_xact_pkg.sv
package div_xact_pkg;

    import fxp_format_pkg::*;

    // ------------------------------------------------------------------------
    // divider sequencing
    // ------------------------------------------------------------------------
    // one quotient bit per cycle, so one step per quotient magnitude bit
    localparam int div_iter  = qmag_w;              // 23 steps
    localparam int div_cnt_w = $clog2(div_iter);    // step counter width

    // ------------------------------------------------------------------------
    // upstream transaction
    // ------------------------------------------------------------------------
    typedef struct packed {
        din_t numerator;                            // Q8.8
        din_t denominator;                          // Q8.8
    } div_operands_t;

    // ------------------------------------------------------------------------
    // downstream transaction
    // ------------------------------------------------------------------------
    // quotient sits in the top bits, status flags at the bottom
    typedef struct packed {
        dout_t quotient;                            // Q12.12, truncated toward zero
        logic  sat;                                 // result was clamped
        logic  div_by_zero;                         // denominator was zero
    } div_result_t;

endpackage

//--- divu_core.sv
`timescale 1ns/10ps

module divu_core (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,     // one-cycle load strobe
    input  logic [fxp_format_pkg::mag_w-1:0] num_mag,   // dividend magnitude, Q7.8
    input  logic [fxp_format_pkg::mag_w-1:0] den_mag,   // divisor magnitude, Q7.8
    output logic                             busy,      // iterating
    output logic                             done,      // one cycle after last step
    output fxp_format_pkg::qmag_t            quo_mag    // Q15.8, held until next start
);

    import fxp_format_pkg::*;
    import div_xact_pkg::*;

    // ------------------------------------------------------------------------
    // datapath state
    // ------------------------------------------------------------------------
    logic [div_cnt_w-1:0] iter_cnt;     // step index
    logic                 last_step;    // final step in progress
    logic [mag_w-1:0]     den_r;        // divisor copy
    logic [mag_w:0]       acc;          // partial remainder, one bit over divisor
    logic [mag_w:0]       acc_sh;       // remainder with next dividend bit shifted in
    logic [mag_w:0]       acc_next;
    qmag_t                quo;          // dividend bits out, quotient bits in
    qmag_t                quo_next;

    assign last_step = busy && (iter_cnt == div_cnt_w'(div_iter - 1));

    // ------------------------------------------------------------------------
    // one restoring step
    // ------------------------------------------------------------------------
    always_comb begin
        acc_sh = {acc[mag_w-1:0], quo[qmag_w-1]};              // bring down msb
        if (acc_sh >= {1'b0, den_r}) begin
            acc_next = acc_sh - {1'b0, den_r};                 // subtract fits
            quo_next = {quo[qmag_w-2:0], 1'b1};
        end else begin
            acc_next = acc_sh;                                 // restore, keep remainder
            quo_next = {quo[qmag_w-2:0], 1'b0};
        end
    end

    // ------------------------------------------------------------------------
    // sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            iter_cnt <= '0;
        end else begin
            done <= 1'b0;                                      // strobe by default
            if (start) begin
                busy     <= 1'b1;
                iter_cnt <= '0;
            end else if (last_step) begin
                busy <= 1'b0;
                done <= 1'b1;                                  // quo_mag valid now
            end else if (busy) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // operand and quotient registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            den_r <= den_mag;
            acc   <= '0;
            quo   <= {num_mag, {din_f{1'b0}}};                 // dividend scaled by 2^din_f
        end else if (busy) begin
            acc <= acc_next;
            quo <= quo_next;
            if (last_step) begin
                quo_mag <= quo_next;                           // holds until next start
            end
        end
    end

endmodule

//--- q_convert.sv
`timescale 1ns/10ps

module q_convert (
    input  logic                   sign,       // 1 for a negative quotient
    input  fxp_format_pkg::qmag_t  quo_mag,    // unsigned Q15.8
    output fxp_format_pkg::dout_t  quotient,   // signed Q12.12
    output logic                   sat         // clamped to a limit
);

    import fxp_format_pkg::*;

    // ------------------------------------------------------------------------
    // alignment and sign
    // ------------------------------------------------------------------------
    logic [align_w-1:0]      mag_al;    // magnitude with 12 fraction bits
    logic signed [align_w:0] sval;      // signed value before clamping

    // low bits were already dropped by the divider, so this is exact
    assign mag_al = {quo_mag, {align_sh{1'b0}}};

    always_comb begin
        if (sign) begin
            sval = -$signed({1'b0, mag_al});                   // two's complement
        end else begin
            sval = $signed({1'b0, mag_al});
        end
    end

    // ------------------------------------------------------------------------
    // range clamp
    // ------------------------------------------------------------------------
    // magnitude was truncated first, so negative results also round toward zero
    always_comb begin
        if (sval > dout_max) begin
            quotient = dout_max;                               // positive overflow
            sat      = 1'b1;
        end else if (sval < dout_min) begin
            quotient = dout_min;                               // negative overflow
            sat      = 1'b1;
        end else begin
            quotient = sval[dout_w-1:0];                       // fits, drop sign ext
            sat      = 1'b0;
        end
    end

endmodule

//--- fxp_divider.sv
`timescale 1ns/10ps

module fxp_divider (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        vld_in,     // operands offered
    output logic                        rdy_out,    // unit empty
    input  div_xact_pkg::div_operands_t operands,
    output logic                        vld_out,    // result waiting
    input  logic                        rdy_in,     // downstream takes result
    output div_xact_pkg::div_result_t   result
);

    import fxp_format_pkg::*;
    import div_xact_pkg::*;

    // ------------------------------------------------------------------------
    // internal signals
    // ------------------------------------------------------------------------
    logic              accept;          // input transfer this edge
    logic              start;           // divider load strobe
    logic              div_busy;
    logic              div_done;
    logic [din_w-1:0]  num_abs;         // full width |numerator|
    logic [din_w-1:0]  den_abs;         // full width |denominator|
    logic [mag_w-1:0]  num_mag_nx;      // magnitudes fitted to the divider
    logic [mag_w-1:0]  den_mag_nx;
    logic [mag_w-1:0]  num_mag;         // captured on accept
    logic [mag_w-1:0]  den_mag;
    logic              sign_q;          // quotient sign
    logic              num_sign;        // picks the div-by-zero limit
    logic              den_zero;
    qmag_t             quo_mag;
    dout_t             conv_quotient;
    logic              conv_sat;
    div_result_t       result_nx;

    // start, busy, done and vld_out cover the whole transaction back to back
    assign rdy_out = !(start || div_busy || div_done || vld_out);
    assign accept  = vld_in && rdy_out;

    // ------------------------------------------------------------------------
    // sign and magnitude split
    // ------------------------------------------------------------------------
    always_comb begin
        num_abs = operands.numerator[din_w-1] ? -operands.numerator : operands.numerator;
        den_abs = operands.denominator[din_w-1] ? -operands.denominator
                                                : operands.denominator;
        if (den_abs[din_w-1]) begin
            // denominator is -128.0, halve both sides, ratio unchanged
            num_mag_nx = num_abs[din_w-1:1];
            den_mag_nx = den_abs[din_w-1:1];
        end else begin
            // -128.0 numerator clamps to max magnitude, 1 lsb short
            num_mag_nx = num_abs[din_w-1] ? {mag_w{1'b1}} : num_abs[mag_w-1:0];
            den_mag_nx = den_abs[mag_w-1:0];
        end
    end

    // ------------------------------------------------------------------------
    // handshake control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start   <= 1'b0;
            vld_out <= 1'b0;
        end else begin
            start <= accept;                                   // one cycle after accept
            if (div_done) begin
                vld_out <= 1'b1;
            end else if (vld_out && rdy_in) begin
                vld_out <= 1'b0;                               // taken
            end
        end
    end

    // ------------------------------------------------------------------------
    // operand capture and result register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            sign_q   <= operands.numerator[din_w-1] ^ operands.denominator[din_w-1];
            num_sign <= operands.numerator[din_w-1];
            den_zero <= (operands.denominator == '0);
            num_mag  <= num_mag_nx;
            den_mag  <= den_mag_nx;
        end
        if (div_done) begin
            result <= result_nx;                               // held until taken
        end
    end

    // zero divisor still runs the divider, its quotient is replaced here
    always_comb begin
        if (den_zero) begin
            result_nx.quotient    = num_sign ? dout_min : dout_max;
            result_nx.sat         = 1'b1;
            result_nx.div_by_zero = 1'b1;
        end else begin
            result_nx.quotient    = conv_quotient;
            result_nx.sat         = conv_sat;
            result_nx.div_by_zero = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // divider and output conversion
    // ------------------------------------------------------------------------
    divu_core u_divu (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .num_mag (num_mag),
        .den_mag (den_mag),
        .busy    (div_busy),
        .done    (div_done),
        .quo_mag (quo_mag)
    );

    q_convert u_conv (
        .sign     (sign_q),
        .quo_mag  (quo_mag),
        .quotient (conv_quotient),
        .sat      (conv_sat)
    );

endmodule

//--- tb_fxp_divider.sv
`timescale 1ns/10ps

module tb_fxp_divider;

    import fxp_format_pkg::*;
    import div_xact_pkg::*;

    // ------------------------------------------------------------------------
    // run constants
    // ------------------------------------------------------------------------
    localparam int latency   = 25;      // accept to vld_out, fixed
    localparam int max_stall = 6;       // longest rdy_in low period
    localparam int max_gap   = 2;       // longest idle gap before vld_in

    logic          clk;
    logic          rst;
    logic          vld_in;
    logic          rdy_out;
    div_operands_t operands;
    logic          vld_out;
    logic          rdy_in;
    div_result_t   result;

    div_operands_t case_ops[$];         // stimulus, in file order
    div_result_t   exp_q[$];            // expected results, popped by monitor

    integer seed = 70;
    int     err_cnt = 0;
    int     chk_cnt = 0;
    int     n_done = 0;                 // results taken so far
    bit     loaded = 0;

    fxp_divider UUT (
        .clk      (clk),
        .rst      (rst),
        .vld_in   (vld_in),
        .rdy_out  (rdy_out),
        .operands (operands),
        .vld_out  (vld_out),
        .rdy_in   (rdy_in),
        .result   (result)
    );

    always #4 clk = ~clk;               // 8 ns period

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic step();
        @(posedge clk);
        #1;                             // drive point after the edge
    endtask

    task automatic check_result(input div_result_t expected, input div_result_t actual,
                                input string name);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("** Error: time %0t, %s: expected q=%h sat=%b dbz=%b, got q=%h sat=%b dbz=%b",
                     $time, name, expected.quotient, expected.sat, expected.div_by_zero,
                     actual.quotient, actual.sat, actual.div_by_zero);
        end
    endtask

    task automatic check_ready(input logic expected, input logic actual, input string name);
        chk_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("** Error: time %0t, %s: expected %b, got %b",
                     $time, name, expected, actual);
        end
    endtask

    // one line per case: num den quotient sat dbz
    task automatic load_cases();
        int            fd;
        int            nf;
        string         line;
        logic [15:0]   n_h;
        logic [15:0]   d_h;
        logic [23:0]   q_h;
        logic          s_h;
        logic          z_h;
        div_operands_t ops;
        div_result_t   exp;
        fd = $fopen("div_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open div_cases.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != 8'h23) begin   // skip # lines
                nf = $sscanf(line, "%h %h %h %h %h", n_h, d_h, q_h, s_h, z_h);
                if (nf == 5) begin
                    ops.numerator       = din_t'(n_h);
                    ops.denominator     = din_t'(d_h);
                    exp.quotient        = dout_t'(q_h);
                    exp.sat             = s_h;
                    exp.div_by_zero     = z_h;
                    case_ops.push_back(ops);
                    exp_q.push_back(exp);
                end
            end
        end
        $fclose(fd);
    endtask

    // offer one pair after a random idle gap, return after the accepting edge
    task automatic send_case(input div_operands_t ops);
        int  gap;
        bit  taken;
        step();
        gap = $unsigned($random(seed)) % (max_gap + 1);
        repeat (gap) step();
        vld_in   = 1'b1;
        operands = ops;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = rdy_out;                                // transfer at next edge
            step();
        end
        vld_in = 1'b0;
    endtask

    task automatic report_and_finish();
        $display("cases %0d, results %0d, checks %0d, errors %0d",
                 case_ops.size(), n_done, chk_cnt, err_cnt);
        if (err_cnt == 0 && n_done == case_ops.size()) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        vld_in   = 1'b0;
        operands = '0;
        rdy_in   = 1'b0;
        load_cases();
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_ready(1'b0, vld_out, "vld_out after reset");  // idle state
        check_ready(1'b1, rdy_out, "rdy_out after reset");
        if (case_ops.size() == 0) begin
            $display("no cases read, nothing was tested");
            $display("** FAIL **");
            $finish;
        end else begin
            loaded = 1'b1;
            foreach (case_ops[i]) begin
                send_case(case_ops[i]);
            end
            wait (n_done == case_ops.size());
            repeat (latency + 5) @(negedge clk);            // catch stray results
            report_and_finish();
        end
    end

    // random back-pressure on the output side
    initial begin
        int stall;
        wait (!rst);
        forever begin
            rdy_in = 1'b1;
            step();
            if (($unsigned($random(seed)) % 3) == 0) begin
                stall  = 1 + ($unsigned($random(seed)) % max_stall);
                rdy_in = 1'b0;
                repeat (stall) step();
            end
        end
    end

    // ------------------------------------------------------------------------
    // result monitor, samples at the falling edge
    // ------------------------------------------------------------------------
    initial begin
        div_result_t held;
        div_result_t exp;
        bit          holding;
        int          errs_before;
        holding = 1'b0;
        wait (!rst);
        forever begin
            @(negedge clk);
            if (vld_out) begin
                check_ready(1'b0, rdy_out, "rdy_out while vld_out");
                if (holding) begin
                    check_result(held, result, "result held");  // must stay stable
                end
                if (rdy_in) begin                               // taken at next edge
                    holding = 1'b0;
                    if (exp_q.size() == 0) begin
                        err_cnt++;
                        $display("result at time %0t has no case waiting for it", $time);
                    end else begin
                        exp         = exp_q.pop_front();
                        errs_before = err_cnt;
                        check_result(exp, result, "result");
                        $display("case %0d: %h / %h -> q=%h sat=%b dbz=%b %s",
                                 n_done, case_ops[n_done].numerator,
                                 case_ops[n_done].denominator, result.quotient,
                                 result.sat, result.div_by_zero,
                                 (err_cnt == errs_before) ? "ok" : "mismatch");
                        n_done++;
                    end
                end else begin
                    held    = result;
                    holding = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------------------
    initial begin
        int budget;
        wait (loaded);
        budget = case_ops.size() * (latency + max_stall + 4 + max_gap) + 2 * latency;
        repeat (budget) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d results seen",
                 budget, n_done, case_ops.size());
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- list.f
fxp_format_pkg.sv
div_xact_pkg.sv
divu_core.sv
q_convert.sv
fxp_divider.sv
tb_fxp_divider.sv

//--- run.sh
#!/bin/sh
# build and run the fxp_divider testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    -f list.f \
    --top-module tb_fxp_divider \
    --Mdir obj_dir \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- div_cases.txt
# numerator denominator quotient sat div_by_zero, all hex
# operands are signed Q8.8, quotient is signed Q12.12 truncated toward zero
0600 0200 003000 0 0
fa00 0200 ffd000 0 0
0600 fe00 ffd000 0 0
fa00 fe00 003000 0 0
0180 0180 001000 0 0
0100 0300 000550 0 0
ff00 0300 fffab0 0 0
0100 fd00 fffab0 0 0
0280 00c0 003550 0 0
fd80 00c0 ffcab0 0 0
0003 0007 0006d0 0 0
fffd 0007 fff930 0 0
0001 7fff 000000 0 0
ffff 7fff 000000 0 0
07c0 ffc0 fe1000 0 0
6400 0080 0c8000 0 0
0000 0300 000000 0 0
0000 fd00 000000 0 0
7fff 0001 7fffff 1 0
8001 0001 800000 1 0
7fff ffff 800000 1 0
6400 0008 7fffff 1 0
4000 0008 7fffff 1 0
c000 0008 800000 0 0
8000 0008 800000 1 0
8000 fff8 7fffff 1 0
8000 8000 001000 0 0
4000 8000 fff800 0 0
0500 0000 7fffff 1 1
fb00 0000 800000 1 1
0000 0000 7fffff 1 1
